// ==== Bender.yml ====
package:
  name: hires_pixel_pipeline

export_include_dirs:
  - .

sources:
  - hires_pkg.sv
  - hires_phase_gen.sv
  - hires_fetch_delay.sv
  - hires_shifter.sv
  - hires_color_resolve.sv
  - hires_pixel_pipeline.sv
  - target: simulation
    files:
      - hires_pixel_pipeline_properties.sv
      - tb_hires_pixel_pipeline.sv

// ==== compile.f ====
+incdir+.
hires_pkg.sv
hires_phase_gen.sv
hires_fetch_delay.sv
hires_shifter.sv
hires_color_resolve.sv
hires_pixel_pipeline.sv
hires_pixel_pipeline_properties.sv
tb_hires_pixel_pipeline.sv

// ==== hires_cfg.svh ====
`ifndef HIRES_CFG_SVH
`define HIRES_CFG_SVH

// one phi cycle spans 8 dots of 4 dot clock ticks each
`define HIRES_TICKS_PER_PHI 32

// character cycles in one raster line
`define HIRES_CYCLES_PER_LINE 65

// tick within the phi cycle where the character bytes are taken
`define HIRES_TICK_FETCH 10

// ticks within the phi cycle where the delayed bytes are handed to the shifter
`define HIRES_TICK_PL_LO 14
`define HIRES_TICK_PL_HI 30

// first and last character cycle of the visible window
`define HIRES_VISIBLE_FIRST 15
`define HIRES_VISIBLE_LAST 54

// fetch strobes a byte waits before it reaches its display slot
`define HIRES_FETCH_DELAY 5

`endif

// ==== hires_color_resolve.sv ====
`timescale 1ns/1ps

module hires_color_resolve (
    input  logic                   clk_dot4x,
    input  logic                   rst_n,
    input  logic                   stage0,
    input  hires_pkg::hires_mode_t mode,
    input  logic                   border_s0,
    input  hires_pkg::pix_pair_t   pix_value,
    input  hires_pkg::pix_pair_t   pix_value2,
    input  hires_pkg::color_t      col_shift,
    input  logic                   half_ff,
    input  hires_pkg::color_t      b0c,
    input  hires_pkg::color_t      ec,
    output hires_pkg::color_t      pixel_color,
    output logic                   pixel_valid
);

    // background and border colours as seen by the previous pixel slot
    hires_pkg::color_t b0c_r;
    hires_pkg::color_t ec_r;

    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            b0c_r       <= '0;
            ec_r        <= '0;
            pixel_color <= '0;
            pixel_valid <= 1'b0;
        end else begin
            pixel_valid <= stage0;
            if (stage0) begin
                b0c_r <= b0c;
                ec_r  <= ec;
                if (border_s0) begin
                    pixel_color <= ec_r;
                end else begin
                    unique case (mode)
                        hires_pkg::MODE_TEXT,
                        hires_pkg::MODE_BITMAP: begin
                            // only the low nibble of the colour byte is used
                            pixel_color <= pix_value[1] ? col_shift : b0c_r;
                        end
                        hires_pkg::MODE_PLANAR16: begin
                            // the second half of a wide pixel repeats the first
                            if (half_ff) begin
                                pixel_color <= {pix_value2, pix_value};
                            end
                        end
                        hires_pkg::MODE_PLANAR4: begin
                            pixel_color <= {2'b00, pix_value2[1], pix_value[1]};
                        end
                    endcase
                end
            end
        end
    end

endmodule

// ==== hires_fetch_delay.sv ====
`timescale 1ns/1ps

`include "hires_cfg.svh"

module hires_fetch_delay (
    input  logic                   clk_dot4x,
    input  logic                   rst_n,
    input  logic                   phi,
    input  logic                   start_dav,
    input  logic                   start_fetch,
    input  logic                   start_pl,
    input  hires_pkg::cycle_num_t  cycle_num,
    input  hires_pkg::bit_pos_t    xscroll,
    input  logic                   vborder,
    input  hires_pkg::pixel_byte_t pixel_data,
    input  hires_pkg::pixel_byte_t color_data,
    output hires_pkg::pixel_byte_t pix_delayed,
    output hires_pkg::pixel_byte_t col_delayed,
    output hires_pkg::bit_pos_t    xscroll_delayed,
    output hires_pkg::cycle_num_t  cycle_delayed
);

    hires_pkg::pixel_byte_t pix_chain [`HIRES_FETCH_DELAY];
    hires_pkg::pixel_byte_t col_chain [`HIRES_FETCH_DELAY];
    hires_pkg::cycle_num_t  cycle_d0;
    hires_pkg::cycle_num_t  cycle_d1;
    hires_pkg::bit_pos_t    xscroll_d0;
    logic                   visible;
    logic                   pl_low;

    assign visible = (cycle_num >= hires_pkg::cycle_num_t'(`HIRES_VISIBLE_FIRST)) &&
                     (cycle_num <= hires_pkg::cycle_num_t'(`HIRES_VISIBLE_LAST));

    // the handover in the low phi half also moves the cycle number and scroll
    assign pl_low = start_pl && !phi;

    // each fetch pushes the newest byte pair in and ages the older ones by one slot
    always_ff @(posedge clk_dot4x) begin
        if (start_fetch) begin
            pix_chain[0] <= pixel_data;
            col_chain[0] <= color_data;
            for (int i = 1; i < `HIRES_FETCH_DELAY; i++) begin
                pix_chain[i] <= pix_chain[i-1];
                col_chain[i] <= col_chain[i-1];
            end
        end
        if (start_pl) begin
            pix_delayed <= pix_chain[`HIRES_FETCH_DELAY-1];
            col_delayed <= col_chain[`HIRES_FETCH_DELAY-1];
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            cycle_d0        <= '0;
            cycle_d1        <= '0;
            cycle_delayed   <= '0;
            xscroll_d0      <= '0;
            xscroll_delayed <= '0;
        end else begin
            if (start_dav) begin
                cycle_d0   <= cycle_num;
                cycle_d1   <= cycle_d0;
                xscroll_d0 <= xscroll;
            end
            if (pl_low) begin
                cycle_delayed <= cycle_d1;
                // the scroll is frozen outside the active display area
                if (visible && !vborder) begin
                    xscroll_delayed <= xscroll_d0;
                end
            end
        end
    end

endmodule

// ==== hires_phase_gen.sv ====
`timescale 1ns/1ps

`include "hires_cfg.svh"

module hires_phase_gen (
    input  logic                  clk_dot4x,
    input  logic                  rst_n,
    output hires_pkg::dot_phase_t dot_rising,
    output logic                  phi,
    output logic                  start_dav,
    output logic                  start_fetch,
    output logic                  start_pl,
    output hires_pkg::cycle_num_t cycle_num,
    output hires_pkg::bit_pos_t   hires_bit
);

    // tick position within the current phi cycle
    logic [4:0] tick;
    logic [4:0] tick_nxt;
    logic       phi_wrap;
    logic       odd_phase;
    logic       line_wrap;

    assign phi_wrap  = (tick == 5'(`HIRES_TICKS_PER_PHI - 1));
    assign tick_nxt  = phi_wrap ? 5'd0 : tick + 5'd1;
    assign line_wrap = (cycle_num == hires_pkg::cycle_num_t'(`HIRES_CYCLES_PER_LINE - 1));
    assign odd_phase = dot_rising[1] || dot_rising[3];

    // all strobes are decoded from the next tick so they line up with the counter
    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            tick        <= '0;
            dot_rising  <= '0;
            phi         <= 1'b0;
            start_dav   <= 1'b0;
            start_fetch <= 1'b0;
            start_pl    <= 1'b0;
        end else begin
            tick        <= tick_nxt;
            dot_rising  <= hires_pkg::dot_phase_t'(4'b0001 << tick_nxt[1:0]);
            phi         <= (tick_nxt >= 5'(`HIRES_TICKS_PER_PHI / 2));
            start_dav   <= (tick_nxt == 5'd0);
            start_fetch <= (tick_nxt == 5'(`HIRES_TICK_FETCH));
            start_pl    <= (tick_nxt == 5'(`HIRES_TICK_PL_LO)) ||
                           (tick_nxt == 5'(`HIRES_TICK_PL_HI));
        end
    end

    // the character cycle moves on together with the start_dav strobe
    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            cycle_num <= '0;
        end else if (phi_wrap) begin
            if (line_wrap) begin
                cycle_num <= '0;
            end else begin
                cycle_num <= cycle_num + 7'd1;
            end
        end
    end

    // two hires pixels per dot, so the counter runs through a character every 4 dots
    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            hires_bit <= '0;
        end else if (odd_phase) begin
            hires_bit <= hires_bit + 3'd1;
        end
    end

endmodule

// ==== hires_pixel_pipeline.sv ====
`timescale 1ns/1ps

module hires_pixel_pipeline (
    input  logic                   clk_dot4x,
    input  logic                   rst_n,
    input  hires_pkg::hires_mode_t mode,
    input  hires_pkg::bit_pos_t    xscroll,
    input  hires_pkg::color_t      b0c,
    input  hires_pkg::color_t      ec,
    input  logic                   main_border,
    input  logic                   vborder,
    input  hires_pkg::pixel_byte_t pixel_data,
    input  hires_pkg::pixel_byte_t color_data,
    output logic                   char_fetch,
    output hires_pkg::color_t      pixel_color,
    output logic                   pixel_valid
);

    hires_pkg::dot_phase_t  dot_rising;
    logic                   phi;
    logic                   start_dav;
    logic                   start_pl;
    hires_pkg::cycle_num_t  cycle_num;
    hires_pkg::bit_pos_t    hires_bit;
    hires_pkg::pixel_byte_t pix_delayed;
    hires_pkg::pixel_byte_t col_delayed;
    hires_pkg::bit_pos_t    xscroll_delayed;
    hires_pkg::cycle_num_t  cycle_delayed;
    hires_pkg::pix_pair_t   pix_value;
    hires_pkg::pix_pair_t   pix_value2;
    hires_pkg::color_t      col_shift;
    logic                   half_ff;
    logic                   border_s0;
    logic                   stage0;

    // the fetch strobe is also the request for the next byte pair
    hires_phase_gen phase_gen_i (
        .clk_dot4x   (clk_dot4x),
        .rst_n       (rst_n),
        .dot_rising  (dot_rising),
        .phi         (phi),
        .start_dav   (start_dav),
        .start_fetch (char_fetch),
        .start_pl    (start_pl),
        .cycle_num   (cycle_num),
        .hires_bit   (hires_bit)
    );

    hires_fetch_delay fetch_delay_i (
        .clk_dot4x       (clk_dot4x),
        .rst_n           (rst_n),
        .phi             (phi),
        .start_dav       (start_dav),
        .start_fetch     (char_fetch),
        .start_pl        (start_pl),
        .cycle_num       (cycle_num),
        .xscroll         (xscroll),
        .vborder         (vborder),
        .pixel_data      (pixel_data),
        .color_data      (color_data),
        .pix_delayed     (pix_delayed),
        .col_delayed     (col_delayed),
        .xscroll_delayed (xscroll_delayed),
        .cycle_delayed   (cycle_delayed)
    );

    hires_shifter shifter_i (
        .clk_dot4x       (clk_dot4x),
        .rst_n           (rst_n),
        .dot_rising      (dot_rising),
        .hires_bit       (hires_bit),
        .mode            (mode),
        .main_border     (main_border),
        .vborder         (vborder),
        .pix_delayed     (pix_delayed),
        .col_delayed     (col_delayed),
        .xscroll_delayed (xscroll_delayed),
        .cycle_delayed   (cycle_delayed),
        .pix_value       (pix_value),
        .pix_value2      (pix_value2),
        .col_shift       (col_shift),
        .half_ff         (half_ff),
        .border_s0       (border_s0),
        .stage0          (stage0)
    );

    hires_color_resolve color_resolve_i (
        .clk_dot4x   (clk_dot4x),
        .rst_n       (rst_n),
        .stage0      (stage0),
        .mode        (mode),
        .border_s0   (border_s0),
        .pix_value   (pix_value),
        .pix_value2  (pix_value2),
        .col_shift   (col_shift),
        .half_ff     (half_ff),
        .b0c         (b0c),
        .ec          (ec),
        .pixel_color (pixel_color),
        .pixel_valid (pixel_valid)
    );

endmodule

// ==== hires_pixel_pipeline_properties.sv ====
`timescale 1ns/1ps

module hires_pixel_pipeline_properties (
    input logic clk_dot4x,
    input logic rst_n,
    input logic pixel_valid,
    input logic char_fetch
);

    // count of assertion failures over the whole run
    int unsigned failures = 0;

    // the colour pulse is cleared by the first reset edge
    a_valid_in_reset: assert property (@(posedge clk_dot4x) !rst_n |=> !pixel_valid)
        else begin
            $error("pixel_valid high during reset");
            failures++;
        end

    a_valid_spacing: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
        pixel_valid |=> !pixel_valid)
        else begin
            $error("pixel_valid high on two consecutive cycles");
            failures++;
        end

    // one fetch per phi cycle of 32 ticks
    a_fetch_period: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
        char_fetch |-> ##1 (!char_fetch)[*31] ##1 char_fetch)
        else begin
            $error("char_fetch not spaced by 32 cycles");
            failures++;
        end

endmodule

bind hires_pixel_pipeline hires_pixel_pipeline_properties props_i (
    .clk_dot4x   (clk_dot4x),
    .rst_n       (rst_n),
    .pixel_valid (pixel_valid),
    .char_fetch  (char_fetch)
);

// ==== hires_pkg.sv ====
package hires_pkg;

    // 4-bit colour index as it leaves the pixel path
    typedef logic [3:0] color_t;

    // one fetched pixel byte or colour byte
    typedef logic [7:0] pixel_byte_t;

    // character cycle number within a raster line
    typedef logic [6:0] cycle_num_t;

    // hires pixel position within a character and the fine scroll value
    typedef logic [2:0] bit_pos_t;

    // one-hot dot phase where bit k marks tick k of a dot
    typedef logic [3:0] dot_phase_t;

    // pair of bits shifted out of a pixel or colour plane
    typedef logic [1:0] pix_pair_t;

    // the high bit selects the planar modes where the colour byte is a second plane
    typedef enum logic [1:0] {
        MODE_TEXT     = 2'b00,
        MODE_BITMAP   = 2'b01,
        MODE_PLANAR16 = 2'b10,
        MODE_PLANAR4  = 2'b11
    } hires_mode_t;

endpackage

// ==== hires_shifter.sv ====
`timescale 1ns/1ps

`include "hires_cfg.svh"

module hires_shifter (
    input  logic                   clk_dot4x,
    input  logic                   rst_n,
    input  hires_pkg::dot_phase_t  dot_rising,
    input  hires_pkg::bit_pos_t    hires_bit,
    input  hires_pkg::hires_mode_t mode,
    input  logic                   main_border,
    input  logic                   vborder,
    input  hires_pkg::pixel_byte_t pix_delayed,
    input  hires_pkg::pixel_byte_t col_delayed,
    input  hires_pkg::bit_pos_t    xscroll_delayed,
    input  hires_pkg::cycle_num_t  cycle_delayed,
    output hires_pkg::pix_pair_t   pix_value,
    output hires_pkg::pix_pair_t   pix_value2,
    output hires_pkg::color_t      col_shift,
    output logic                   half_ff,
    output logic                   border_s0,
    output logic                   stage0
);

    hires_pkg::pixel_byte_t pix_bits;
    hires_pkg::pixel_byte_t col_bits;
    hires_pkg::pixel_byte_t pix_src;
    hires_pkg::pixel_byte_t col_src;
    logic                   odd_phase;
    logic                   even_phase;
    logic                   load;
    logic                   visible_d;

    assign odd_phase  = dot_rising[1] || dot_rising[3];
    assign even_phase = dot_rising[0] || dot_rising[2];
    assign load       = (hires_bit == xscroll_delayed);
    assign visible_d  = (cycle_delayed >= hires_pkg::cycle_num_t'(`HIRES_VISIBLE_FIRST)) &&
                        (cycle_delayed <= hires_pkg::cycle_num_t'(`HIRES_VISIBLE_LAST));

    // on a scroll match the fresh bytes replace the shifter contents before the shift
    always_comb begin
        pix_src = pix_bits;
        col_src = col_bits;
        if (load) begin
            if (visible_d && !vborder) begin
                pix_src = pix_delayed;
                col_src = col_delayed;
            end else begin
                pix_src = '0;
                col_src = '0;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            pix_bits   <= '0;
            col_bits   <= '0;
            pix_value  <= '0;
            pix_value2 <= '0;
            half_ff    <= 1'b0;
            border_s0  <= 1'b0;
            stage0     <= 1'b0;
        end else begin
            stage0 <= odd_phase;
            if (odd_phase) begin
                border_s0 <= main_border;
                pix_value <= pix_src[7:6];
                pix_bits  <= {pix_src[6:0], 1'b0};
                // planar modes treat the colour byte as a second bit plane
                if (mode[1]) begin
                    pix_value2 <= col_src[7:6];
                    col_bits   <= {col_src[6:0], 1'b0};
                end else begin
                    col_bits <= col_src;
                end
            end
            // half_ff marks the first of the two hires slots of a 320-wide pixel
            if (odd_phase && load) begin
                half_ff <= 1'b1;
            end else if (even_phase) begin
                half_ff <= ~half_ff;
            end
        end
    end

    assign col_shift = col_bits[3:0];

endmodule

// ==== tb_hires_pixel_pipeline.sv ====
`timescale 1ns/1ps

`include "hires_cfg.svh"

module tb_hires_pixel_pipeline;

    localparam int LINE_CYCLES = `HIRES_TICKS_PER_PHI * `HIRES_CYCLES_PER_LINE;
    localparam int STREAM_TESTS = 8;
    // each stream test settles for two lines and compares one more
    localparam int CYCLE_LIMIT = (STREAM_TESTS * 3 + 2) * LINE_CYCLES;
    localparam int MAX_CHARS = CYCLE_LIMIT / `HIRES_TICKS_PER_PHI + 8;

    logic                   clk_dot4x;
    logic                   rst_n;
    hires_pkg::hires_mode_t mode;
    hires_pkg::bit_pos_t    xscroll;
    hires_pkg::color_t      b0c;
    hires_pkg::color_t      ec;
    logic                   main_border;
    logic                   vborder;
    hires_pkg::pixel_byte_t pixel_data;
    hires_pkg::pixel_byte_t color_data;
    logic                   char_fetch;
    hires_pkg::color_t      pixel_color;
    logic                   pixel_valid;

    logic [31:0]            lfsr_state;
    int                     cyc;
    int                     watchdog;
    hires_pkg::pixel_byte_t rec_pix [MAX_CHARS];
    hires_pkg::pixel_byte_t rec_col [MAX_CHARS];

    hires_pixel_pipeline dut_i (
        .clk_dot4x   (clk_dot4x),
        .rst_n       (rst_n),
        .mode        (mode),
        .xscroll     (xscroll),
        .b0c         (b0c),
        .ec          (ec),
        .main_border (main_border),
        .vborder     (vborder),
        .pixel_data  (pixel_data),
        .color_data  (color_data),
        .char_fetch  (char_fetch),
        .pixel_color (pixel_color),
        .pixel_valid (pixel_valid)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #2 clk_dot4x = ~clk_dot4x;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [7:0] random_bits(input int count);
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[6:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    // cyc equals the tick count since reset, so cyc / 32 is the character cycle
    always @(posedge clk_dot4x) begin
        if (!rst_n) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    // a new byte pair is offered on every fetch strobe and kept for the model
    always @(negedge clk_dot4x) begin
        if (rst_n && char_fetch) begin
            pixel_data = random_bits(8);
            color_data = random_bits(8);
            rec_pix[cyc / `HIRES_TICKS_PER_PHI] = pixel_data;
            rec_col[cyc / `HIRES_TICKS_PER_PHI] = color_data;
        end
    end

    always @(posedge clk_dot4x) begin
        watchdog <= watchdog + 1;
        if (watchdog >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $fatal(1);
        end
    end

    task automatic check_color(input hires_pkg::color_t got, input hires_pkg::color_t exp,
                               input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // expected colour of the pulse at tick n as built from the recorded fetches
    function automatic hires_pkg::color_t expect_pixel(input int n);
        int m;
        int load_edge;
        int j;
        int k;
        int cd;
        int cyc_d;
        hires_pkg::pixel_byte_t pb;
        hires_pkg::pixel_byte_t cb;
        m = n - 2;
        // loads happen on the odd tick where the hires bit meets the scroll
        load_edge = m - ((m - (2 * xscroll + 1)) % 16);
        j = (m - load_edge) / 2;
        cd = load_edge / `HIRES_TICKS_PER_PHI;
        if ((load_edge % `HIRES_TICKS_PER_PHI) <= `HIRES_TICK_PL_LO) begin
            cd = cd - 1;
        end
        cyc_d = (cd - 1) % `HIRES_CYCLES_PER_LINE;
        pb = '0;
        cb = '0;
        if (cyc_d >= `HIRES_VISIBLE_FIRST && cyc_d <= `HIRES_VISIBLE_LAST && !vborder) begin
            // the byte's own fetch is the first strobe of the delay chain
            pb = rec_pix[cd - (`HIRES_FETCH_DELAY - 1)];
            cb = rec_col[cd - (`HIRES_FETCH_DELAY - 1)];
        end
        if (main_border) begin
            return ec;
        end
        case (mode)
            hires_pkg::MODE_PLANAR16: begin
                k = 7 - (j & 6);
                return {cb[k], cb[k-1], pb[k], pb[k-1]};
            end
            hires_pkg::MODE_PLANAR4: begin
                return {2'b00, cb[7-j], pb[7-j]};
            end
            default: begin
                return pb[7-j] ? cb[3:0] : b0c;
            end
        endcase
    endfunction

    task automatic test_reset();
        int first;
        rst_n = 1'b0;
        repeat (4) begin
            @(negedge clk_dot4x);
            check_flag(pixel_valid, 1'b0, "pixel_valid in reset");
            check_flag(char_fetch, 1'b0, "char_fetch in reset");
        end
        rst_n = 1'b1;
        while (!pixel_valid) @(negedge clk_dot4x);
        first = cyc;
        repeat (64) begin
            @(negedge clk_dot4x);
            check_flag(pixel_valid, ((cyc - first) % 2) == 0, "pixel_valid cadence");
        end
    endtask

    task automatic run_stream(input hires_pkg::hires_mode_t m, input hires_pkg::bit_pos_t xs,
                              input logic mb, input logic vb, input string what);
        int fetches;
        @(negedge clk_dot4x);
        mode        = m;
        xscroll     = xs;
        main_border = mb;
        vborder     = vb;
        b0c         = hires_pkg::color_t'(random_bits(4));
        ec          = hires_pkg::color_t'(random_bits(4));
        fetches = 0;
        while (fetches < 2 * `HIRES_CYCLES_PER_LINE) begin
            @(negedge clk_dot4x);
            if (char_fetch) fetches++;
        end
        repeat (`HIRES_CYCLES_PER_LINE * 16) begin
            @(negedge clk_dot4x);
            while (!pixel_valid) @(negedge clk_dot4x);
            check_flag((cyc % 2) == 1, 1'b1, "pixel_valid tick parity");
            check_color(pixel_color, expect_pixel(cyc), what);
        end
    endtask

    initial begin
        lfsr_state  = 32'h50e3_7d23;
        watchdog    = 0;
        rst_n       = 1'b0;
        mode        = hires_pkg::MODE_TEXT;
        xscroll     = '0;
        b0c         = '0;
        ec          = '0;
        main_border = 1'b0;
        vborder     = 1'b0;
        pixel_data  = '0;
        color_data  = '0;
        test_reset();
        run_stream(hires_pkg::MODE_TEXT, 3'd0, 1'b0, 1'b0, "text pixel");
        run_stream(hires_pkg::MODE_BITMAP, 3'd0, 1'b0, 1'b0, "bitmap pixel");
        run_stream(hires_pkg::MODE_TEXT, 3'd0, 1'b1, 1'b0, "main border pixel");
        run_stream(hires_pkg::MODE_TEXT, 3'd0, 1'b0, 1'b1, "vertical border pixel");
        run_stream(hires_pkg::MODE_PLANAR4, 3'd0, 1'b0, 1'b0, "640 planar pixel");
        run_stream(hires_pkg::MODE_PLANAR16, 3'd0, 1'b0, 1'b0, "320 planar pixel");
        run_stream(hires_pkg::MODE_TEXT, 3'd3, 1'b0, 1'b0, "scrolled text pixel");
        run_stream(hires_pkg::MODE_TEXT, 3'd6, 1'b0, 1'b0, "scrolled text pixel");
        // the bound assertions flag their failures without stopping the run
        if (dut_i.props_i.failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
